//--- ramio.f
+incdir+src
src/ramio_pkg.sv
src/ram_port_if.sv
src/access_steer.sv
src/word_ram.sv
src/io_regs.sv
src/uart_tx.sv
src/uart_rx.sv
src/ramio_top.sv
bench/tb_ramio.sv

//--- bench/tb_ramio.sv
// --------------------------------------------------------------------
// ramio testbench
// random accesses against a memory, led and uart reference model,
// with a serial line driver and sampler for both uart halves
// --------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "ramio_settings.svh"

module tb_ramio;
  import ramio_pkg::*;

  localparam int bit_clks = `RAMIO_UART_BIT_CLKS;
  localparam int ram_words = `RAMIO_RAM_WORDS;
  localparam int idx_w = $clog2(ram_words);
  // test lengths
  localparam int n_word = 300;
  localparam int n_sub = 200;
  localparam int n_mis = 20;
  localparam int n_led = 4;
  localparam int n_tx = 4;
  localparam int n_rx = 4;
  // cycles allowed for data_out_ready on a memory access
  localparam int ready_limit = 4;
  // watchdog budget of 4 cycles per access and 12 bit times per frame
  localparam int n_access = ram_words + 2 * n_word + 3 * (n_sub + n_mis) + 2 * n_led
                            + 3 * n_tx + 2 * n_rx + 2;
  localparam int limit_clks = 4 * n_access + 12 * bit_clks * (n_tx + n_rx) + 1000;

  logic        clk;
  logic        rst_n;
  logic        enable;
  logic [2:0]  read_type;
  size_e       write_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic [3:0]  led;
  logic        uart_tx;
  logic        uart_rx;

  // reference memory
  logic [31:0] mem_model [ram_words];
  // reference led register
  logic [3:0]  led_model;
  int          errors = 0;
  int          checks = 0;

  ramio_top DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .read_type      (read_type),
    .write_type     (write_type),
    .address        (address),
    .data_in        (data_in),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .led            (led),
    .uart_tx        (uart_tx),
    .uart_rx        (uart_rx)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // watchdog
  initial begin
    repeat (limit_clks) @(posedge clk);
    $display("timeout: run still busy after %0d cycles", limit_clks);
    $display("Result: FAILED");
    $finish;
  end

  // --------------------------------------------------------------------
  // model helpers
  // --------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, got %h", name, expected, actual);
    end
  endtask

  // random memory address for a word index and lane offset
  function automatic logic [31:0] mem_addr(input logic [idx_w-1:0] idx, input logic [1:0] off);
    logic [31:0] a;
    a = $urandom();
    a[idx_w+1:0] = {idx, off};
    // keep the whole word clear of the i/o map
    if (a[31:2] == `RAMIO_ADDR_LED >> 2 || a[31:2] == `RAMIO_ADDR_UART_OUT >> 2 ||
        a[31:2] == `RAMIO_ADDR_UART_IN >> 2) begin
      a[31] = 1'b0;
    end
    return a;
  endfunction

  // byte enabled update that drops misaligned halves
  function automatic void apply_write(input size_e sz, input logic [31:0] a,
                                      input logic [31:0] d);
    int k;
    k = a[idx_w+1:2];
    case (sz)
      size_byte: mem_model[k][8*a[1:0] +: 8] = d[7:0];
      size_half: begin
        if (!a[0]) begin
          mem_model[k][16*a[1] +: 16] = d[15:0];
        end
      end
      size_word: mem_model[k] = d;
      default: ;
    endcase
  endfunction

  // lane pick with sign or zero extension
  function automatic logic [31:0] expect_read(input logic [2:0] rtype, input logic [31:0] w,
                                              input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] r;
    b = w[8*off +: 8];
    h = w[16*off[1] +: 16];
    r = w;
    if (rtype[1:0] == 2'(size_byte)) begin
      r = rtype[2] ? {{24{b[7]}}, b} : {24'h0, b};
    end else if (rtype[1:0] == 2'(size_half)) begin
      if (off[0]) begin
        r = 32'h0;
      end else begin
        r = rtype[2] ? {{16{h[15]}}, h} : {16'h0, h};
      end
    end
    return r;
  endfunction

  // --------------------------------------------------------------------
  // bus access
  // --------------------------------------------------------------------
  // one access held until data_out_ready and then one idle cycle
  task automatic run_access(input logic [2:0] rtype, input size_e wtype,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int   waited;
    logic io;
    io = addr == `RAMIO_ADDR_LED || addr == `RAMIO_ADDR_UART_OUT ||
         addr == `RAMIO_ADDR_UART_IN;
    @(posedge clk);
    #1;
    enable     = 1'b1;
    read_type  = rtype;
    write_type = wtype;
    address    = addr;
    data_in    = wdata;
    waited     = 0;
    @(negedge clk);
    while (!data_out_ready && waited < ready_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!data_out_ready) begin
      errors++;
      $display("access to %h never raised data_out_ready", addr);
    end else if (io && waited != 0) begin
      errors++;
      $display("data_out_ready was late on an i/o access to %h", addr);
    end else if (!io && waited != 1) begin
      errors++;
      $display("data_out_ready did not rise one cycle after enable on %h", addr);
    end
    rdata = data_out;
    @(posedge clk);
    #1;
    enable     = 1'b0;
    read_type  = 3'b000;
    write_type = size_none;
  endtask

  task automatic bus_write(input size_e wtype, input logic [31:0] addr, input logic [31:0] d);
    logic [31:0] unused;
    run_access(3'b000, wtype, addr, d, unused);
  endtask

  task automatic bus_read(input logic [2:0] rtype, input logic [31:0] addr,
                          input logic [31:0] expected, input string what);
    logic [31:0] got;
    run_access(rtype, size_none, addr, 32'h0, got);
    check_value($sformatf("data_out @%h (%s)", addr, what), expected, got);
  endtask

  // --------------------------------------------------------------------
  // serial line
  // --------------------------------------------------------------------
  // 8n1 frame onto uart_rx with lsb first
  task automatic drive_rx_frame(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    @(posedge clk);
    for (int i = 0; i < 10; i++) begin
      #1;
      uart_rx = frame[i];
      repeat (bit_clks) @(posedge clk);
    end
  endtask

  // waits for a start bit and then samples each bit at its middle
  task automatic sample_tx_frame(output logic [7:0] b);
    int waited;
    b = 8'h00;
    waited = 0;
    @(negedge clk);
    while (uart_tx && waited < 2) begin
      @(negedge clk);
      waited++;
    end
    if (uart_tx) begin
      errors++;
      $display("uart_tx start bit did not begin within 2 cycles of the write");
    end else begin
      repeat (bit_clks / 2) @(negedge clk);
      if (uart_tx !== 1'b0) begin
        errors++;
        $display("uart_tx start bit ended early");
      end
      for (int i = 0; i < 8; i++) begin
        repeat (bit_clks) @(negedge clk);
        b[i] = uart_tx;
      end
      repeat (bit_clks) @(negedge clk);
      if (uart_tx !== 1'b1) begin
        errors++;
        $display("uart_tx stop bit was low");
      end
    end
  endtask

  // --------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------
  task automatic word_test();
    logic [idx_w-1:0] idx;
    logic [31:0]      d;
    // fill every word first so no read sees an unknown
    for (int i = 0; i < ram_words; i++) begin
      d = $urandom();
      bus_write(size_word, mem_addr(i, 2'b00), d);
      mem_model[i] = d;
    end
    for (int i = 0; i < n_word; i++) begin
      idx = $urandom_range(ram_words - 1, 0);
      d = $urandom();
      bus_write(size_word, mem_addr(idx, 2'b00), d);
      apply_write(size_word, {22'h0, idx, 2'b00}, d);
      idx = $urandom_range(ram_words - 1, 0);
      bus_read(3'b011, mem_addr(idx, 2'b00), mem_model[idx], "word read");
    end
  endtask

  task automatic subword_test(input bit misaligned);
    logic [idx_w-1:0] idx;
    logic [1:0]       off;
    logic [31:0]      addr;
    logic [31:0]      d;
    size_e            sz;
    logic [2:0]       rtype;
    for (int i = 0; i < (misaligned ? n_mis : n_sub); i++) begin
      idx = $urandom_range(ram_words - 1, 0);
      d = $urandom();
      if (misaligned) begin
        // offsets 1 and 3 only
        sz = size_half;
        off = $urandom_range(1, 0) ? 2'd3 : 2'd1;
      end else begin
        sz = $urandom_range(1, 0) ? size_half : size_byte;
        off = $urandom_range(3, 0);
        if (sz == size_half) begin
          off[0] = 1'b0;
        end
      end
      addr = mem_addr(idx, off);
      bus_write(sz, addr, d);
      apply_write(sz, addr, d);
      // untouched lanes must survive
      bus_read(3'b011, {addr[31:2], 2'b00}, mem_model[idx], "word after narrow write");
      if (misaligned) begin
        rtype = {1'($urandom_range(1, 0)), size_half};
        bus_read(rtype, addr, 32'h0, "misaligned half read");
      end else begin
        sz = $urandom_range(1, 0) ? size_half : size_byte;
        off = $urandom_range(3, 0);
        if (sz == size_half) begin
          off[0] = 1'b0;
        end
        rtype = {1'($urandom_range(1, 0)), sz};
        bus_read(rtype, mem_addr(idx, off), expect_read(rtype, mem_model[idx], off),
                 rtype[2] ? "signed narrow read" : "unsigned narrow read");
      end
    end
  endtask

  task automatic led_test();
    logic [31:0] d;
    for (int i = 0; i < n_led; i++) begin
      d = $urandom();
      // every write moves the nibble away from the current leds
      if (d[3:0] == led_model) begin
        d[3:0] = ~d[3:0];
      end
      bus_write(size_word, `RAMIO_ADDR_LED, d);
      led_model = d[3:0];
      check_value("led", {28'h0, led_model}, {28'h0, led});
    end
  endtask

  task automatic uart_tx_test();
    logic [7:0]  b;
    logic [7:0]  got;
    logic [31:0] d;
    for (int i = 0; i < n_tx; i++) begin
      d = $urandom();
      b = d[7:0];
      bus_write(size_byte, `RAMIO_ADDR_UART_OUT, d);
      fork
        sample_tx_frame(got);
        begin
          // byte still in flight mid frame
          repeat (3 * bit_clks) @(posedge clk);
          bus_read(3'b011, `RAMIO_ADDR_UART_OUT, {24'h0, b}, "uart out in flight");
        end
      join
      check_value("uart_tx byte", {24'h0, b}, {24'h0, got});
      repeat (bit_clks) @(posedge clk);
      bus_read(3'b011, `RAMIO_ADDR_UART_OUT, 32'hffff_ffff, "uart out after frame");
    end
  endtask

  task automatic uart_rx_test();
    logic [7:0] b;
    for (int i = 0; i < n_rx; i++) begin
      b = $urandom_range(255, 0);
      drive_rx_frame(b);
      repeat (bit_clks) @(posedge clk);
      bus_read(3'b011, `RAMIO_ADDR_UART_IN, {24'h0, b}, "uart in byte");
      // a read empties the holding word
      bus_read(3'b011, `RAMIO_ADDR_UART_IN, 32'hffff_ffff, "uart in after read");
    end
  endtask

  // --------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------
  initial begin
    void'($urandom(81));
    rst_n      = 1'b0;
    enable     = 1'b0;
    read_type  = 3'b000;
    write_type = size_none;
    address    = 32'h0;
    data_in    = 32'h0;
    uart_rx    = 1'b1;
    led_model  = 4'hf;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset state
    @(negedge clk);
    check_value("led", {28'h0, led_model}, {28'h0, led});
    check_value("uart_tx", 32'h1, {31'h0, uart_tx});
    bus_read(3'b011, `RAMIO_ADDR_UART_OUT, 32'hffff_ffff, "uart out after reset");
    bus_read(3'b011, `RAMIO_ADDR_UART_IN, 32'hffff_ffff, "uart in after reset");

    word_test();
    subword_test(1'b0);
    subword_test(1'b1);
    led_test();
    uart_tx_test();
    uart_rx_test();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/ramio_top.sv
// --------------------------------------------------------------------
// ramio top
// bus bridge to on-chip word memory, four leds and an 8n1 uart
// --------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "ramio_settings.svh"

module ramio_top (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      enable,
  input  wire [2:0]                read_type,
  input  wire ramio_pkg::size_e    write_type,
  input  wire [`RAMIO_ADDR_W-1:0]  address,
  input  wire [`RAMIO_DATA_W-1:0]  data_in,
  output logic [`RAMIO_DATA_W-1:0] data_out,
  output logic                     data_out_ready,
  output logic [3:0]               led,
  output logic                     uart_tx,
  input  wire                      uart_rx
);
  import ramio_pkg::*;

  // steering to i/o registers
  io_sel_e    io_sel;
  logic       io_rd;
  logic       io_wr;
  logic [7:0] io_wdata;
  word_t      io_rdata;

  // uart handshakes
  logic [7:0] tx_byte;
  logic       tx_go;
  logic       tx_busy;
  logic [7:0] rx_byte;
  logic       rx_go;
  logic       rx_ready;

  ram_port_if ram_bus ();

  access_steer u_steer (
    .enable         (enable),
    .read_type      (read_type),
    .write_type     (write_type),
    .address        (address),
    .data_in        (data_in),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .ram            (ram_bus),
    .io_sel         (io_sel),
    .io_rd          (io_rd),
    .io_wr          (io_wr),
    .io_wdata       (io_wdata),
    .io_rdata       (io_rdata)
  );

  word_ram u_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .port  (ram_bus)
  );

  io_regs u_io (
    .clk      (clk),
    .rst_n    (rst_n),
    .io_sel   (io_sel),
    .io_rd    (io_rd),
    .io_wr    (io_wr),
    .io_wdata (io_wdata),
    .io_rdata (io_rdata),
    .led      (led),
    .tx_byte  (tx_byte),
    .tx_go    (tx_go),
    .tx_busy  (tx_busy),
    .rx_go    (rx_go),
    .rx_byte  (rx_byte),
    .rx_ready (rx_ready)
  );

  uart_tx u_uart_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_go   (tx_go),
    .tx_byte (tx_byte),
    .tx_busy (tx_busy),
    .tx      (uart_tx)
  );

  uart_rx u_uart_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (uart_rx),
    .rx_go    (rx_go),
    .rx_byte  (rx_byte),
    .rx_ready (rx_ready)
  );

endmodule

`default_nettype wire

//--- src/uart_rx.sv
// --------------------------------------------------------------------
// uart receiver
// 8n1 deserializer, samples each bit at mid bit time
// --------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "ramio_settings.svh"

module uart_rx (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx,
  input  wire        rx_go,
  output logic [7:0] rx_byte,
  output logic       rx_ready
);
  localparam int bit_clks = `RAMIO_UART_BIT_CLKS;
  localparam int cnt_w    = $clog2(bit_clks);

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop,
    rx_done
  } rx_state_e;

  rx_state_e        state;
  logic [cnt_w-1:0] cnt;
  logic [2:0]       bit_idx;
  // two-flop synchronizer
  logic             rx_meta;
  logic             rx_sync;
  logic             half_end;
  logic             bit_end;

  assign half_end = cnt == cnt_w'(bit_clks / 2 - 1);
  assign bit_end  = cnt == cnt_w'(bit_clks - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      state   <= rx_idle;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      cnt     <= bit_end ? '0 : cnt + 1'b1;
      case (state)
        // wait for the falling edge of a start bit
        rx_idle: begin
          cnt <= '0;
          if (rx_go && !rx_sync) begin
            state <= rx_start;
          end
        end
        // recheck at mid start bit
        // then count whole bits from there
        rx_start: begin
          if (half_end) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= rx_stop;
            end
          end
        end
        // bad stop bit drops the frame
        rx_stop: begin
          if (bit_end) begin
            state <= rx_sync ? rx_done : rx_idle;
          end
        end
        // hold ready until acknowledged
        rx_done: begin
          if (!rx_go) begin
            state <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clk) begin
    if (state == rx_data && bit_end) begin
      rx_byte <= {rx_sync, rx_byte[7:1]};
    end
  end

  assign rx_ready = state == rx_done;

endmodule

`default_nettype wire

//--- src/uart_tx.sv
// --------------------------------------------------------------------
// uart transmitter
// 8n1 serializer, lsb first, paced by the bit-time count
// --------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "ramio_settings.svh"

module uart_tx (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       tx_go,
  input  wire [7:0] tx_byte,
  output logic      tx_busy,
  output logic      tx
);
  localparam int bit_clks = `RAMIO_UART_BIT_CLKS;
  localparam int cnt_w    = $clog2(bit_clks);

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_e;

  tx_state_e  state;
  logic [cnt_w-1:0] cnt;
  logic [2:0] bit_idx;
  logic [7:0] shreg;
  // frame done, waiting for go to drop
  logic       sent;
  logic       bit_end;

  assign bit_end = cnt == cnt_w'(bit_clks - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= tx_idle;
      cnt     <= '0;
      bit_idx <= '0;
      sent    <= 1'b0;
    end else begin
      cnt <= bit_end ? '0 : cnt + 1'b1;
      case (state)
        tx_idle: begin
          cnt <= '0;
          if (!tx_go) begin
            sent <= 1'b0;
          end else if (!sent) begin
            state <= tx_start;
          end
        end
        tx_start: begin
          if (bit_end) begin
            state   <= tx_data;
            bit_idx <= '0;
          end
        end
        tx_data: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= tx_stop;
            end
          end
        end
        tx_stop: begin
          if (bit_end) begin
            state <= tx_idle;
            sent  <= 1'b1;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // shift register, loaded on go
  always_ff @(posedge clk) begin
    if (state == tx_idle && tx_go && !sent) begin
      shreg <= tx_byte;
    end else if (state == tx_data && bit_end) begin
      shreg <= shreg >> 1;
    end
  end

  // busy as soon as go is seen, until the frame is done
  assign tx_busy = (state != tx_idle) || (tx_go && !sent);

  always_comb begin
    case (state)
      tx_start: tx = 1'b0;
      tx_data:  tx = shreg[0];
      default:  tx = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- src/io_regs.sv
// --------------------------------------------------------------------
// i/o registers
// led register, uart transmit and receive holding words, and the
// go and acknowledge sequencing of both uart halves
// --------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module io_regs (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire ramio_pkg::io_sel_e io_sel,
  input  wire                     io_rd,
  input  wire                     io_wr,
  input  wire [7:0]               io_wdata,
  output ramio_pkg::word_t        io_rdata,
  output logic [3:0]              led,
  output logic [7:0]              tx_byte,
  output logic                    tx_go,
  input  wire                     tx_busy,
  output logic                    rx_go,
  input  wire [7:0]               rx_byte,
  input  wire                     rx_ready
);
  import ramio_pkg::*;

  // byte in flight, all-ones when idle
  word_t tx_word;
  // last byte received, all-ones when empty
  word_t rx_word;

  assign tx_byte = tx_word[7:0];

  // register read mux
  always_comb begin
    case (io_sel)
      io_led:      io_rdata = word_t'(led);
      io_uart_out: io_rdata = tx_word;
      io_uart_in:  io_rdata = rx_word;
      default:     io_rdata = '0;
    endcase
  end

  // --------------------------------------------------------------------
  // register updates
  // --------------------------------------------------------------------
  // later assignments win within one clock
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // all leds off
      led     <= 4'b1111;
      tx_word <= '1;
      tx_go   <= 1'b0;
      rx_word <= '1;
      rx_go   <= 1'b1;
    end else begin
      // reading uart in empties it
      if (io_rd && io_sel == io_uart_in) begin
        rx_word <= '1;
      end

      // copy received byte and acknowledge with go low
      // an unread byte is overwritten
      if (rx_go && rx_ready) begin
        rx_word <= word_t'(rx_byte);
        rx_go   <= 1'b0;
      end

      // one cycle low is enough
      if (!rx_go) begin
        rx_go <= 1'b1;
      end

      // frame sent so release go and go idle
      if (tx_go && !tx_busy) begin
        tx_go   <= 1'b0;
        tx_word <= '1;
      end

      // new byte to send
      if (io_wr && io_sel == io_uart_out) begin
        tx_word <= word_t'(io_wdata);
        tx_go   <= 1'b1;
      end

      if (io_wr && io_sel == io_led) begin
        led <= io_wdata[3:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/word_ram.sv
// --------------------------------------------------------------------
// word ram
// synchronous word memory with byte enables and a read-ready flag
// --------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "ramio_settings.svh"

module word_ram (
  input  wire     clk,
  input  wire     rst_n,
  ram_port_if.mem port
);
  import ramio_pkg::*;

  localparam int idx_w = $clog2(`RAMIO_RAM_WORDS);

  word_t                      mem [`RAMIO_RAM_WORDS];
  logic [idx_w-1:0]           idx;
  logic                       req_q;
  logic [`RAMIO_ADDR_W-1:0]   addr_q;
  logic [`RAMIO_DATA_W/8-1:0] strb_q;
  logic                       same_access;

  // word index wraps modulo the depth
  assign idx = port.addr[idx_w+1:2];

  // byte writes and registered read
  always_ff @(posedge clk) begin
    if (port.req) begin
      for (int b = 0; b < `RAMIO_DATA_W / 8; b++) begin
        if (port.wstrb[b]) begin
          mem[idx][8*b +: 8] <= port.wdata[8*b +: 8];
        end
      end
      port.rdata <= mem[idx];
    end
    addr_q <= port.addr;
    strb_q <= port.wstrb;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q <= 1'b0;
    end else begin
      req_q <= port.req;
    end
  end

  // a new address or strobe restarts the access
  assign same_access = (port.addr == addr_q) && (port.wstrb == strb_q);
  // drops in the same cycle as req
  assign port.rvalid = port.req && req_q && same_access;

endmodule

`default_nettype wire

//--- src/access_steer.sv
// --------------------------------------------------------------------
// access steering
// decodes the client address, builds byte enabled memory writes,
// extracts and extends read lanes and muxes the read data
// --------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "ramio_settings.svh"

module access_steer (
  input  wire                     enable,
  input  wire [2:0]               read_type,
  input  wire ramio_pkg::size_e   write_type,
  input  wire [`RAMIO_ADDR_W-1:0] address,
  input  wire ramio_pkg::word_t   data_in,
  output ramio_pkg::word_t        data_out,
  output logic                    data_out_ready,
  ram_port_if.steer               ram,
  output ramio_pkg::io_sel_e      io_sel,
  output logic                    io_rd,
  output logic                    io_wr,
  output logic [7:0]              io_wdata,
  input  wire ramio_pkg::word_t   io_rdata
);
  import ramio_pkg::*;

  size_e rd_size;
  logic  is_read;
  logic  is_write;
  logic  is_io;
  // read word shifted so the addressed lane sits at bit 0
  word_t lane;
  word_t mem_data;

  // --------------------------------------------------------------------
  // decode
  // --------------------------------------------------------------------
  always_comb begin
    case (address)
      `RAMIO_ADDR_LED:      io_sel = io_led;
      `RAMIO_ADDR_UART_OUT: io_sel = io_uart_out;
      `RAMIO_ADDR_UART_IN:  io_sel = io_uart_in;
      default:              io_sel = io_mem;
    endcase
  end

  // bit 2 of read_type is the sign flag
  assign rd_size  = size_e'(read_type[1:0]);
  assign is_read  = rd_size != size_none;
  assign is_write = write_type != size_none;
  assign is_io    = io_sel != io_mem;

  // register strobes only while enabled
  assign io_rd    = enable && is_io && is_read;
  assign io_wr    = enable && is_io && is_write;
  assign io_wdata = data_in[7:0];

  // --------------------------------------------------------------------
  // memory write
  // --------------------------------------------------------------------
  assign ram.req  = enable && !is_io && (is_read || is_write);
  // word aligned, the lane comes from address[1:0]
  assign ram.addr = {address[`RAMIO_ADDR_W-1:2], 2'b00};

  always_comb begin
    ram.wstrb = '0;
    ram.wdata = '0;
    if (is_write) begin
      case (write_type)
        size_byte: begin
          ram.wstrb = 4'b0001 << address[1:0];
          ram.wdata = word_t'(data_in[7:0]) << {address[1:0], 3'b000};
        end
        size_half: begin
          // odd offsets enable nothing
          if (!address[0]) begin
            ram.wstrb = 4'b0011 << {address[1], 1'b0};
            ram.wdata = word_t'(data_in[15:0]) << {address[1], 4'b0000};
          end
        end
        size_word: begin
          ram.wstrb = '1;
          ram.wdata = data_in;
        end
        default: ;
      endcase
    end
  end

  // --------------------------------------------------------------------
  // memory read
  // --------------------------------------------------------------------
  assign lane = ram.rdata >> {address[1:0], 3'b000};

  always_comb begin
    mem_data = '0;
    case (rd_size)
      size_byte: begin
        mem_data = read_type[2] ? {{24{lane[7]}}, lane[7:0]} : {24'h0, lane[7:0]};
      end
      size_half: begin
        // misaligned half word reads as zero
        if (!address[0]) begin
          mem_data = read_type[2] ? {{16{lane[15]}}, lane[15:0]} : {16'h0, lane[15:0]};
        end
      end
      size_word: mem_data = ram.rdata;
      default: ;
    endcase
  end

  // i/o answers in the same cycle
  // memory answers once its word is registered
  assign data_out       = !(enable && is_read) ? '0 : (is_io ? io_rdata : mem_data);
  assign data_out_ready = is_io || ram.rvalid;

endmodule

`default_nettype wire

//--- src/ram_port_if.sv
// --------------------------------------------------------------------
// ram port interface
// one word access from the bus steering to the on-chip memory
// --------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "ramio_settings.svh"

interface ram_port_if;
  import ramio_pkg::*;

  // access presented while high
  logic                       req;
  // word aligned byte address
  logic [`RAMIO_ADDR_W-1:0]   addr;
  // byte enables, all zero for a read
  logic [`RAMIO_DATA_W/8-1:0] wstrb;
  word_t                      wdata;
  // registered read word
  word_t                      rdata;
  // high from the clock after req rises while the access is held
  logic                       rvalid;

  modport steer (output req, addr, wstrb, wdata, input rdata, rvalid);
  modport mem (input req, addr, wstrb, wdata, output rdata, rvalid);

endinterface

`default_nettype wire

//--- src/ramio_pkg.sv
// --------------------------------------------------------------------
// ramio package
// access size and i/o select encodings, data word type
// --------------------------------------------------------------------
`default_nettype none
`include "ramio_settings.svh"

package ramio_pkg;

  // one data word on the client bus
  typedef logic [`RAMIO_DATA_W-1:0] word_t;

  // access size
  // write_type uses all of it, read_type only its low two bits
  typedef enum logic [1:0] {
    size_none = 2'b00,
    size_byte = 2'b01,
    size_half = 2'b10,
    size_word = 2'b11
  } size_e;

  // result of address decode
  typedef enum logic [1:0] {
    io_mem      = 2'b00,
    io_led      = 2'b01,
    io_uart_out = 2'b10,
    io_uart_in  = 2'b11
  } io_sel_e;

endpackage

`default_nettype wire

//--- src/ramio_settings.svh
// --------------------------------------------------------------------
// ramio settings
// bus widths, memory depth, i/o address map and uart bit time
// --------------------------------------------------------------------
`ifndef RAMIO_SETTINGS_SVH
`define RAMIO_SETTINGS_SVH

// client bus widths
`define RAMIO_ADDR_W 32
`define RAMIO_DATA_W 32

// on-chip memory depth in words
`define RAMIO_RAM_WORDS 256

// i/o map at the top of the address space
// leds sit in the low nibble and are active low
`define RAMIO_ADDR_LED      32'hffff_fffc
// reads back all-ones while the transmitter is idle
`define RAMIO_ADDR_UART_OUT 32'hffff_fff8
// a read empties the holding word back to all-ones
`define RAMIO_ADDR_UART_IN  32'hffff_fff4

// clock cycles per serial bit
`define RAMIO_UART_BIT_CLKS 16

`endif
